/* logic/chunk_addr_looper.sv */
/*
  request nchunk must lie in 1..MAX_CHUNKS, zero is not handled
  one block at a time, the next request waits for the last address
*/
module chunk_addr_looper (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_req_valid,
	output logic                               o_req_ready,
	input  tile_read_pkg::gaddr_t              i_req_addr,
	input  logic [tile_read_pkg::CHUNK_BW-1:0] i_req_nchunk,
	output logic                               o_alloc_valid,
	input  logic                               i_alloc_ready,
	output logic                               o_job_valid,
	input  logic                               i_job_ready,
	output logic                               o_dramra_valid,
	input  logic                               i_dramra_ready,
	output tile_read_pkg::gaddr_t              o_dramra_addr
);
	logic                               busy;
	logic [tile_read_pkg::CHUNK_BW-1:0] left;
	tile_read_pkg::gaddr_t              addr;
	logic                               req_take;
	logic                               ra_take;

	// request, grant and job push move together
	assign o_req_ready   = !busy && i_alloc_ready && i_job_ready;
	assign o_alloc_valid = i_req_valid && !busy && i_job_ready;
	assign o_job_valid   = i_req_valid && !busy && i_alloc_ready;
	assign req_take      = i_req_valid && o_req_ready;

	assign o_dramra_valid = busy;
	assign o_dramra_addr  = addr;
	assign ra_take        = busy && i_dramra_ready;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			busy <= 1'b0;
			left <= '0;
		end else if (req_take) begin
			busy <= 1'b1;
			left <= i_req_nchunk;
		end else if (ra_take) begin
			busy <= (left != tile_read_pkg::CHUNK_BW'(1));
			left <= left - 1'b1;
		end
	end

	// chunk address steps by one beat of words
	always_ff @(posedge i_clk) begin
		if (req_take) begin
			addr <= i_req_addr;
		end else if (ra_take) begin
			addr <= addr + tile_read_pkg::GADDR_BW'(tile_read_pkg::CSIZE);
		end
	end
endmodule

/* logic/remap_buffer.sv */
/*
  VSIZE single-word banks, one row of a slot spread across all of them
  write and read of the same row in one cycle returns old data
  read data shows one cycle after i_rd_en
*/
module remap_buffer #(
	parameter  int N_SLOTS = 4,
	localparam int SLOT_BW = $clog2(N_SLOTS)
) (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_wr_en,
	input  logic [SLOT_BW-1:0]               i_wr_slot,
	input  logic [tile_read_pkg::ROW_BW-1:0] i_wr_row,
	input  logic [tile_read_pkg::XOR_BW-1:0] i_wr_xor,
	input  tile_read_pkg::vec_t              i_wr_data,
	input  logic                             i_rd_en,
	input  logic [SLOT_BW-1:0]               i_rd_slot,
	input  logic [tile_read_pkg::ROW_BW-1:0] i_rd_row,
	input  logic [tile_read_pkg::XOR_BW-1:0] i_rd_xor,
	output tile_read_pkg::vec_t              o_rd_vec
);
	localparam int VSIZE   = tile_read_pkg::VSIZE;
	localparam int DBW     = tile_read_pkg::DATA_BW;
	localparam int XBW     = tile_read_pkg::XOR_BW;
	localparam int DEPTH   = N_SLOTS * tile_read_pkg::SLOT_ROWS;
	localparam int ADDR_BW = SLOT_BW + tile_read_pkg::ROW_BW;

	tile_read_pkg::data_t bank    [VSIZE][DEPTH];
	tile_read_pkg::data_t wr_word [VSIZE];
	tile_read_pkg::data_t rd_word [VSIZE];
	logic [ADDR_BW-1:0]   wr_addr;
	logic [ADDR_BW-1:0]   rd_addr;
	logic [XBW-1:0]       wr_mask;
	logic [XBW-1:0]       rd_mask;
	logic [XBW-1:0]       rd_mask_q;

	assign wr_addr = {i_wr_slot, i_wr_row};
	assign rd_addr = {i_rd_slot, i_rd_row};
	assign wr_mask = i_wr_row[XBW-1:0] & i_wr_xor;
	assign rd_mask = i_rd_row[XBW-1:0] & i_rd_xor;

	// ==============================
	// write side swizzle
	// ==============================
	// lane L goes to bank L ^ mask, so bank B takes lane B ^ mask
	always_comb begin
		for (int b = 0; b < VSIZE; b++) begin
			wr_word[b] = i_wr_data[(XBW'(b) ^ wr_mask) * DBW +: DBW];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			for (int b = 0; b < VSIZE; b++) begin
				bank[b][wr_addr] <= wr_word[b];
			end
		end
		if (i_rd_en) begin
			for (int b = 0; b < VSIZE; b++) begin
				rd_word[b] <= bank[b][rd_addr];
			end
		end
	end

	// mask follows the read data by one cycle
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			rd_mask_q <= '0;
		end else if (i_rd_en) begin
			rd_mask_q <= rd_mask;
		end
	end

	// ==============================
	// read side unswizzle
	// ==============================
	always_comb begin
		for (int l = 0; l < VSIZE; l++) begin
			o_rd_vec[l*DBW +: DBW] = rd_word[XBW'(l) ^ rd_mask_q];
		end
	end
endmodule

/* logic/slot_allocator.sv */
/*
  circular free list of buffer slot ids, full after reset
  frees are always taken, the caller never frees an id twice
*/
module slot_allocator #(
	parameter  int N_SLOTS = 4,
	localparam int SLOT_BW = $clog2(N_SLOTS)
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_alloc_valid,
	output logic               o_alloc_ready,
	output logic [SLOT_BW-1:0] o_alloc_slot,
	input  logic               i_free_valid,
	input  logic [SLOT_BW-1:0] i_free_slot
);
	localparam int CNT_BW = $clog2(N_SLOTS + 1);

	logic [SLOT_BW-1:0] free_list [N_SLOTS];
	logic [SLOT_BW-1:0] rd_ptr;
	logic [SLOT_BW-1:0] wr_ptr;
	logic [CNT_BW-1:0]  count;
	logic               pop;

	function automatic logic [SLOT_BW-1:0] next_ptr(input logic [SLOT_BW-1:0] p);
		return (p == SLOT_BW'(N_SLOTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign o_alloc_ready = (count != '0);
	assign o_alloc_slot  = free_list[rd_ptr];
	assign pop           = i_alloc_valid && o_alloc_ready;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			for (int i = 0; i < N_SLOTS; i++) begin
				free_list[i] <= SLOT_BW'(i);
			end
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= CNT_BW'(N_SLOTS);
		end else begin
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (i_free_valid) begin
				free_list[wr_ptr] <= i_free_slot;
				wr_ptr            <= next_ptr(wr_ptr);
			end
			// grant and free may land in the same cycle
			count <= count + CNT_BW'(i_free_valid) - CNT_BW'(pop);
		end
	end
endmodule

/* logic/sram_write_collector.sv */
/*
  DRAM beats arrive in request order, one job entry per block
  a beat is split into two rows, one per cycle
  a new block's beats wait until the previous done entry is taken
*/
module sram_write_collector #(
	parameter  int N_SLOTS = 4,
	localparam int SLOT_BW = $clog2(N_SLOTS)
) (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_job_valid,
	output logic                               o_job_ready,
	input  logic [SLOT_BW-1:0]                 i_job_slot,
	input  logic [tile_read_pkg::CHUNK_BW-1:0] i_job_nchunk,
	input  logic [tile_read_pkg::XOR_BW-1:0]   i_job_xor,
	input  logic                               i_dramrd_valid,
	output logic                               o_dramrd_ready,
	input  tile_read_pkg::beat_t               i_dramrd_data,
	output logic                               o_wr_en,
	output logic [SLOT_BW-1:0]                 o_wr_slot,
	output logic [tile_read_pkg::ROW_BW-1:0]   o_wr_row,
	output logic [tile_read_pkg::XOR_BW-1:0]   o_wr_xor,
	output tile_read_pkg::vec_t                o_wr_data,
	output logic                               o_done_valid,
	input  logic                               i_done_ready,
	output logic [SLOT_BW-1:0]                 o_done_slot,
	output logic [tile_read_pkg::NROW_BW-1:0]  o_done_nrows,
	output logic [tile_read_pkg::XOR_BW-1:0]   o_done_xor
);
	localparam int VW = $bits(tile_read_pkg::vec_t);
	localparam int NB = tile_read_pkg::NROW_BW;

	// ==============================
	// job queue, two entries
	// ==============================
	logic [SLOT_BW-1:0]               q_slot  [2];
	logic [NB-1:0]                    q_nrows [2];
	logic [tile_read_pkg::XOR_BW-1:0] q_xor   [2];
	logic                             q_head;
	logic                             q_tail;
	logic [1:0]                       q_cnt;
	logic                             job_push;

	tile_read_pkg::beat_t             beat;
	logic                             wr_lo;
	logic                             wr_hi;
	logic [tile_read_pkg::ROW_BW-1:0] row;
	logic                             last_row;
	logic                             beat_take;

	assign o_job_ready = (q_cnt != 2'd2);
	assign job_push    = i_job_valid && o_job_ready;

	// blocks hold an even row count, so the last row is always a high half
	assign last_row = wr_hi && (NB'(row) == q_nrows[q_head] - 1'b1);

	// no beat while the low row is pending or a done entry waits
	assign o_dramrd_ready = (q_cnt != 2'd0) && !wr_lo && !last_row && !o_done_valid;
	assign beat_take      = i_dramrd_valid && o_dramrd_ready;

	assign o_wr_en   = wr_lo || wr_hi;
	assign o_wr_slot = q_slot[q_head];
	assign o_wr_row  = row;
	assign o_wr_xor  = q_xor[q_head];
	assign o_wr_data = wr_lo ? beat[VW-1:0] : beat[2*VW-1:VW];

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			q_head       <= 1'b0;
			q_tail       <= 1'b0;
			q_cnt        <= 2'd0;
			wr_lo        <= 1'b0;
			wr_hi        <= 1'b0;
			row          <= '0;
			o_done_valid <= 1'b0;
		end else begin
			if (job_push) begin
				q_tail <= ~q_tail;
			end
			if (last_row) begin
				q_head <= ~q_head;
			end
			q_cnt <= q_cnt + 2'(job_push) - 2'(last_row);
			wr_lo <= beat_take;
			wr_hi <= wr_lo;
			if (o_wr_en) begin
				row <= last_row ? '0 : row + 1'b1;
			end
			if (last_row) begin
				o_done_valid <= 1'b1;
			end else if (i_done_ready) begin
				o_done_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (job_push) begin
			q_slot[q_tail]  <= i_job_slot;
			q_nrows[q_tail] <= NB'(i_job_nchunk) * NB'(tile_read_pkg::CHUNK_ROWS);
			q_xor[q_tail]   <= i_job_xor;
		end
		if (beat_take) begin
			beat <= i_dramrd_data;
		end
		if (last_row) begin
			o_done_slot  <= q_slot[q_head];
			o_done_nrows <= q_nrows[q_head];
			o_done_xor   <= q_xor[q_head];
		end
	end
endmodule

/* logic/tile_read_pipeline.sv */
/*
  read side of the tile accumulation unit
  N_SLOTS from 2 to 8 buffer slots, each holding one block
  DRAM must return read data in address order
*/
module tile_read_pipeline #(
	parameter int N_SLOTS = 4
) (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_req_valid,
	output logic                               o_req_ready,
	input  tile_read_pkg::gaddr_t              i_req_addr,
	input  logic [tile_read_pkg::CHUNK_BW-1:0] i_req_nchunk,
	input  logic [tile_read_pkg::XOR_BW-1:0]   i_req_xor,
	output logic                               o_dramra_valid,
	input  logic                               i_dramra_ready,
	output tile_read_pkg::gaddr_t              o_dramra_addr,
	input  logic                               i_dramrd_valid,
	output logic                               o_dramrd_ready,
	input  tile_read_pkg::beat_t               i_dramrd_data,
	output logic                               o_rd_valid,
	input  logic                               i_rd_ready,
	output tile_read_pkg::vec_t                o_rd_data,
	output logic                               o_rd_last
);
	localparam int SLOT_BW = $clog2(N_SLOTS);

	logic                              alloc_valid;
	logic                              alloc_ready;
	logic [SLOT_BW-1:0]                alloc_slot;
	logic                              job_valid;
	logic                              job_ready;
	logic                              wr_en;
	logic [SLOT_BW-1:0]                wr_slot;
	logic [tile_read_pkg::ROW_BW-1:0]  wr_row;
	logic [tile_read_pkg::XOR_BW-1:0]  wr_xor;
	tile_read_pkg::vec_t               wr_data;
	logic                              done_valid;
	logic                              done_ready;
	logic [SLOT_BW-1:0]                done_slot;
	logic [tile_read_pkg::NROW_BW-1:0] done_nrows;
	logic [tile_read_pkg::XOR_BW-1:0]  done_xor;
	logic                              rd_en;
	logic [SLOT_BW-1:0]                rd_slot;
	logic [tile_read_pkg::ROW_BW-1:0]  rd_row;
	logic [tile_read_pkg::XOR_BW-1:0]  rd_xor;
	tile_read_pkg::vec_t               rd_vec;
	logic                              free_valid;
	logic [SLOT_BW-1:0]                free_slot;

	// ==============================
	// input side
	// ==============================
	chunk_addr_looper u_addr_looper (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.o_req_ready    (o_req_ready),
		.i_req_addr     (i_req_addr),
		.i_req_nchunk   (i_req_nchunk),
		.o_alloc_valid  (alloc_valid),
		.i_alloc_ready  (alloc_ready),
		.o_job_valid    (job_valid),
		.i_job_ready    (job_ready),
		.o_dramra_valid (o_dramra_valid),
		.i_dramra_ready (i_dramra_ready),
		.o_dramra_addr  (o_dramra_addr)
	);

	slot_allocator #(.N_SLOTS(N_SLOTS)) u_slot_alloc (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_alloc_valid (alloc_valid),
		.o_alloc_ready (alloc_ready),
		.o_alloc_slot  (alloc_slot),
		.i_free_valid  (free_valid),
		.i_free_slot   (free_slot)
	);

	// ==============================
	// write and storage
	// ==============================
	// job record is the granted slot plus the request's own fields
	sram_write_collector #(.N_SLOTS(N_SLOTS)) u_write_col (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_job_valid    (job_valid),
		.o_job_ready    (job_ready),
		.i_job_slot     (alloc_slot),
		.i_job_nchunk   (i_req_nchunk),
		.i_job_xor      (i_req_xor),
		.i_dramrd_valid (i_dramrd_valid),
		.o_dramrd_ready (o_dramrd_ready),
		.i_dramrd_data  (i_dramrd_data),
		.o_wr_en        (wr_en),
		.o_wr_slot      (wr_slot),
		.o_wr_row       (wr_row),
		.o_wr_xor       (wr_xor),
		.o_wr_data      (wr_data),
		.o_done_valid   (done_valid),
		.i_done_ready   (done_ready),
		.o_done_slot    (done_slot),
		.o_done_nrows   (done_nrows),
		.o_done_xor     (done_xor)
	);

	remap_buffer #(.N_SLOTS(N_SLOTS)) u_remap_buf (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_wr_en   (wr_en),
		.i_wr_slot (wr_slot),
		.i_wr_row  (wr_row),
		.i_wr_xor  (wr_xor),
		.i_wr_data (wr_data),
		.i_rd_en   (rd_en),
		.i_rd_slot (rd_slot),
		.i_rd_row  (rd_row),
		.i_rd_xor  (rd_xor),
		.o_rd_vec  (rd_vec)
	);

	// ==============================
	// output side
	// ==============================
	vector_read_looper #(.N_SLOTS(N_SLOTS)) u_read_looper (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_done_valid (done_valid),
		.o_done_ready (done_ready),
		.i_done_slot  (done_slot),
		.i_done_nrows (done_nrows),
		.i_done_xor   (done_xor),
		.o_rd_en      (rd_en),
		.o_rd_slot    (rd_slot),
		.o_rd_row     (rd_row),
		.o_rd_xor     (rd_xor),
		.i_rd_vec     (rd_vec),
		.o_rd_valid   (o_rd_valid),
		.i_rd_ready   (i_rd_ready),
		.o_rd_data    (o_rd_data),
		.o_rd_last    (o_rd_last),
		.o_free_valid (free_valid),
		.o_free_slot  (free_slot)
	);
endmodule

/* logic/tile_read_pkg.sv */
/*
  shared sizes and word types of the tile read pipeline
  VSIZE must be a power of two, since the bank swizzle XORs lane bits
  CSIZE is assumed to be exactly two rows of VSIZE words
*/
package tile_read_pkg;
	localparam int DATA_BW    = 16;
	localparam int VSIZE      = 4;
	localparam int CSIZE      = 8;
	localparam int MAX_CHUNKS = 4;
	localparam int GADDR_BW   = 24;

	// derived widths
	localparam int CHUNK_BW   = $clog2(MAX_CHUNKS + 1);
	localparam int XOR_BW     = $clog2(VSIZE);
	localparam int CHUNK_ROWS = CSIZE / VSIZE;
	localparam int SLOT_ROWS  = CHUNK_ROWS * MAX_CHUNKS;
	localparam int ROW_BW     = $clog2(SLOT_ROWS);
	// row count of a block, up to SLOT_ROWS inclusive
	localparam int NROW_BW    = $clog2(SLOT_ROWS + 1);

	typedef logic [DATA_BW-1:0]       data_t;
	typedef logic [GADDR_BW-1:0]      gaddr_t;
	typedef logic [CSIZE*DATA_BW-1:0] beat_t;
	typedef logic [VSIZE*DATA_BW-1:0] vec_t;
endpackage

/* logic/vector_read_looper.sv */
/*
  one buffer read in flight plus a two-entry skid keeps one vector per cycle
  the slot is freed when the last vector of its block leaves
*/
module vector_read_looper #(
	parameter  int N_SLOTS = 4,
	localparam int SLOT_BW = $clog2(N_SLOTS)
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic                              i_done_valid,
	output logic                              o_done_ready,
	input  logic [SLOT_BW-1:0]                i_done_slot,
	input  logic [tile_read_pkg::NROW_BW-1:0] i_done_nrows,
	input  logic [tile_read_pkg::XOR_BW-1:0]  i_done_xor,
	output logic                              o_rd_en,
	output logic [SLOT_BW-1:0]                o_rd_slot,
	output logic [tile_read_pkg::ROW_BW-1:0]  o_rd_row,
	output logic [tile_read_pkg::XOR_BW-1:0]  o_rd_xor,
	input  tile_read_pkg::vec_t               i_rd_vec,
	output logic                              o_rd_valid,
	input  logic                              i_rd_ready,
	output tile_read_pkg::vec_t               o_rd_data,
	output logic                              o_rd_last,
	output logic                              o_free_valid,
	output logic [SLOT_BW-1:0]                o_free_slot
);
	localparam int NB = tile_read_pkg::NROW_BW;

	// current block
	logic                             active;
	logic [NB-1:0]                    cur_nrows;
	logic [tile_read_pkg::ROW_BW-1:0] row;
	logic                             last_issue;
	logic                             done_take;

	// read in flight, data on i_rd_vec in the following cycle
	logic                             fly;
	logic                             fly_last;
	logic [SLOT_BW-1:0]               fly_slot;

	// output skid
	tile_read_pkg::vec_t              sk_data [2];
	logic                             sk_last [2];
	logic [SLOT_BW-1:0]               sk_slot [2];
	logic                             sk_head;
	logic                             sk_tail;
	logic [1:0]                       sk_cnt;
	logic [1:0]                       level;
	logic                             pop;

	assign pop   = o_rd_valid && i_rd_ready;
	assign level = sk_cnt + 2'(fly);

	// a slot leaving this cycle makes room for a new read
	assign o_rd_en    = active && (level < 2'd2 || pop);
	assign last_issue = o_rd_en && (NB'(row) == cur_nrows - 1'b1);

	assign o_done_ready = !active || last_issue;
	assign done_take    = i_done_valid && o_done_ready;
	assign o_rd_row     = row;

	assign o_rd_valid   = (sk_cnt != 2'd0);
	assign o_rd_data    = sk_data[sk_head];
	assign o_rd_last    = o_rd_valid && sk_last[sk_head];
	assign o_free_valid = pop && sk_last[sk_head];
	assign o_free_slot  = sk_slot[sk_head];

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active  <= 1'b0;
			row     <= '0;
			fly     <= 1'b0;
			sk_head <= 1'b0;
			sk_tail <= 1'b0;
			sk_cnt  <= 2'd0;
		end else begin
			if (done_take) begin
				active <= 1'b1;
			end else if (last_issue) begin
				active <= 1'b0;
			end
			if (done_take || last_issue) begin
				row <= '0;
			end else if (o_rd_en) begin
				row <= row + 1'b1;
			end
			fly <= o_rd_en;
			if (fly) begin
				sk_tail <= ~sk_tail;
			end
			if (pop) begin
				sk_head <= ~sk_head;
			end
			sk_cnt <= sk_cnt + 2'(fly) - 2'(pop);
		end
	end

	always_ff @(posedge i_clk) begin
		if (done_take) begin
			o_rd_slot <= i_done_slot;
			cur_nrows <= i_done_nrows;
			o_rd_xor  <= i_done_xor;
		end
		if (o_rd_en) begin
			fly_last <= last_issue;
			fly_slot <= o_rd_slot;
		end
		if (fly) begin
			sk_data[sk_tail] <= i_rd_vec;
			sk_last[sk_tail] <= fly_last;
			sk_slot[sk_tail] <= fly_slot;
		end
	end
endmodule

/* tile_read_pipeline.f */
logic/tile_read_pkg.sv
logic/chunk_addr_looper.sv
logic/slot_allocator.sv
logic/sram_write_collector.sv
logic/remap_buffer.sv
logic/vector_read_looper.sv
logic/tile_read_pipeline.sv
verification/tile_read_checker.sv
verification/tile_read_pipeline_tb.sv

/* verification/tile_read_checker.sv */
/*
  scoreboard of the tile read pipeline, it only watches DUT ports
  word k of a DRAM beat at address A is word_hash(A + k)
  blocks between first address and last vector are held to N_SLOTS
*/
module tile_read_checker #(
	parameter int N_SLOTS = 4
) (
	input logic                               i_clk,
	input logic                               i_rst,
	input logic                               i_req_valid,
	input logic                               i_req_ready,
	input tile_read_pkg::gaddr_t              i_req_addr,
	input logic [tile_read_pkg::CHUNK_BW-1:0] i_req_nchunk,
	input logic                               i_dramra_valid,
	input logic                               i_dramra_ready,
	input tile_read_pkg::gaddr_t              i_dramra_addr,
	input logic                               i_dramrd_ready,
	input logic                               i_rd_valid,
	input logic                               i_rd_ready,
	input tile_read_pkg::vec_t                i_rd_data,
	input logic                               i_rd_last
);
	localparam int DBW  = tile_read_pkg::DATA_BW;
	localparam int ROWS = tile_read_pkg::CSIZE / tile_read_pkg::VSIZE;

	tile_read_pkg::gaddr_t exp_addr   [$];
	tile_read_pkg::vec_t   exp_vec    [$];
	logic                  exp_last   [$];
	int                    blk_chunks [$];
	int                    addr_idx   = 0;
	int                    in_use     = 0;
	int                    checks     = 0;
	int                    errors     = 0;
	logic                  after_rst  = 1'b0;
	string                 test_name  = "none";

	function automatic tile_read_pkg::data_t word_hash(input logic [31:0] a);
		logic [31:0] h;
		h = a * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	function automatic int pending();
		return exp_vec.size() + exp_addr.size();
	endfunction

	task automatic start_test(input string name);
		test_name = name;
	endtask

	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	// ==============================
	// expected traffic per request
	// ==============================
	task automatic add_block(input tile_read_pkg::gaddr_t base, input int n);
		tile_read_pkg::gaddr_t caddr;
		tile_read_pkg::vec_t   v;
		for (int c = 0; c < n; c++) begin
			caddr = base + tile_read_pkg::gaddr_t'(c * tile_read_pkg::CSIZE);
			exp_addr.push_back(caddr);
			// each beat gives ROWS vectors in word order
			for (int r = 0; r < ROWS; r++) begin
				for (int l = 0; l < tile_read_pkg::VSIZE; l++) begin
					v[l*DBW +: DBW] = word_hash(32'(caddr) + r * tile_read_pkg::VSIZE + l);
				end
				exp_vec.push_back(v);
				exp_last.push_back(c == n - 1 && r == ROWS - 1);
			end
		end
		blk_chunks.push_back(n);
	endtask

	task automatic note_address();
		if (exp_addr.size() == 0 || blk_chunks.size() == 0) begin
			report($sformatf("DRAM address %h with no request outstanding", i_dramra_addr));
		end else begin
			check_val("dram address", 64'(exp_addr.pop_front()), 64'(i_dramra_addr));
			// first address of a block means its slot is held
			if (addr_idx == 0) begin
				in_use++;
			end
			addr_idx++;
			if (addr_idx == blk_chunks[0]) begin
				addr_idx = 0;
				void'(blk_chunks.pop_front());
			end
			if (in_use > N_SLOTS) begin
				report($sformatf("%0d blocks hold buffer slots, only %0d exist", in_use, N_SLOTS));
			end
		end
	endtask

	task automatic note_vector();
		logic last_exp;
		if (exp_vec.size() == 0) begin
			report("output vector with no block outstanding");
		end else begin
			last_exp = exp_last.pop_front();
			check_val("vector data", exp_vec.pop_front(), i_rd_data);
			check_val("last flag", 64'(last_exp), 64'(i_rd_last));
			if (last_exp) begin
				in_use--;
			end
		end
	endtask

	// ==============================
	// port watch
	// ==============================
	always @(posedge i_clk) begin : watch
		if (!i_rst || after_rst) begin
			check_val("reset o_req_ready", 64'(1), 64'(i_req_ready));
			check_val("reset o_dramra_valid", 64'(0), 64'(i_dramra_valid));
			check_val("reset o_dramrd_ready", 64'(0), 64'(i_dramrd_ready));
			check_val("reset o_rd_valid", 64'(0), 64'(i_rd_valid));
		end
		after_rst = !i_rst;
		if (i_rst) begin
			if (i_req_valid && i_req_ready) begin
				add_block(i_req_addr, int'(i_req_nchunk));
			end
			if (i_dramra_valid && i_dramra_ready) begin
				note_address();
			end
			if (i_rd_valid && i_rd_ready) begin
				note_vector();
			end
		end
	end
endmodule

/* verification/tile_read_pipeline_tb.sv */
/*
  random requests from seed 68 against a DRAM model that answers in order
  DRAM beats follow random gaps of up to three cycles
  expected traffic lives in the checker instance
*/
module tile_read_pipeline_tb;
	localparam int N_SLOTS = 4;
	localparam int TIMEOUT = 20000;

	typedef struct packed {
		tile_read_pkg::gaddr_t              addr;
		logic [tile_read_pkg::CHUNK_BW-1:0] nchunk;
		logic [tile_read_pkg::XOR_BW-1:0]   xmask;
	} req_t;

	logic                               i_clk;
	logic                               i_rst;
	logic                               i_req_valid;
	logic                               o_req_ready;
	tile_read_pkg::gaddr_t              i_req_addr;
	logic [tile_read_pkg::CHUNK_BW-1:0] i_req_nchunk;
	logic [tile_read_pkg::XOR_BW-1:0]   i_req_xor;
	logic                               o_dramra_valid;
	logic                               i_dramra_ready;
	tile_read_pkg::gaddr_t              o_dramra_addr;
	logic                               i_dramrd_valid;
	logic                               o_dramrd_ready;
	tile_read_pkg::beat_t               i_dramrd_data;
	logic                               o_rd_valid;
	logic                               i_rd_ready;
	tile_read_pkg::vec_t                o_rd_data;
	logic                               o_rd_last;

	req_t                  req_q  [$];
	tile_read_pkg::gaddr_t addr_q [$];
	int                    gap;
	logic                  ra_random;
	// 0 always ready, 1 random, 2 held low
	int                    rd_mode;
	int                    tests_run;
	int                    tests_failed;
	int                    checks_seen;
	int                    errors_seen;
	logic                  timed_out;

	tile_read_pipeline #(.N_SLOTS(N_SLOTS)) u_tile_read_pipeline (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.o_req_ready    (o_req_ready),
		.i_req_addr     (i_req_addr),
		.i_req_nchunk   (i_req_nchunk),
		.i_req_xor      (i_req_xor),
		.o_dramra_valid (o_dramra_valid),
		.i_dramra_ready (i_dramra_ready),
		.o_dramra_addr  (o_dramra_addr),
		.i_dramrd_valid (i_dramrd_valid),
		.o_dramrd_ready (o_dramrd_ready),
		.i_dramrd_data  (i_dramrd_data),
		.o_rd_valid     (o_rd_valid),
		.i_rd_ready     (i_rd_ready),
		.o_rd_data      (o_rd_data),
		.o_rd_last      (o_rd_last)
	);

	tile_read_checker #(.N_SLOTS(N_SLOTS)) u_checker (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.i_req_ready    (o_req_ready),
		.i_req_addr     (i_req_addr),
		.i_req_nchunk   (i_req_nchunk),
		.i_dramra_valid (o_dramra_valid),
		.i_dramra_ready (i_dramra_ready),
		.i_dramra_addr  (o_dramra_addr),
		.i_dramrd_ready (o_dramrd_ready),
		.i_rd_valid     (o_rd_valid),
		.i_rd_ready     (i_rd_ready),
		.i_rd_data      (o_rd_data),
		.i_rd_last      (o_rd_last)
	);

	initial begin
		i_clk = 1'b0;
		forever begin
			#2 i_clk = ~i_clk;
		end
	end

	// ==============================
	// input drive at 1 unit after the edge
	// ==============================
	always @(posedge i_clk) begin : drive_inputs
		logic                  req_fire;
		logic                  ra_fire;
		logic                  rd_fire;
		tile_read_pkg::gaddr_t a;
		req_fire = i_req_valid && o_req_ready;
		ra_fire  = o_dramra_valid && i_dramra_ready;
		rd_fire  = i_dramrd_valid && o_dramrd_ready;
		if (ra_fire) begin
			addr_q.push_back(o_dramra_addr);
		end
		#1;
		if (req_fire) begin
			void'(req_q.pop_front());
			i_req_valid = 1'b0;
		end
		if (!i_req_valid && req_q.size() != 0) begin
			i_req_valid  = 1'b1;
			i_req_addr   = req_q[0].addr;
			i_req_nchunk = req_q[0].nchunk;
			i_req_xor    = req_q[0].xmask;
		end
		if (rd_fire) begin
			i_dramrd_valid = 1'b0;
		end
		// DRAM answers in address order after a random gap
		if (!i_dramrd_valid && addr_q.size() != 0) begin
			if (gap == 0) begin
				a = addr_q.pop_front();
				for (int k = 0; k < tile_read_pkg::CSIZE; k++) begin
					i_dramrd_data[k*tile_read_pkg::DATA_BW +: tile_read_pkg::DATA_BW] =
						u_checker.word_hash(32'(a) + k);
				end
				i_dramrd_valid = 1'b1;
				gap = $urandom_range(0, 3);
			end else begin
				gap--;
			end
		end
		i_dramra_ready = ra_random ? 1'($urandom_range(0, 1)) : 1'b1;
		case (rd_mode)
			0:       i_rd_ready = 1'b1;
			1:       i_rd_ready = 1'($urandom_range(0, 1));
			default: i_rd_ready = 1'b0;
		endcase
	end

	task automatic queue_request(input tile_read_pkg::gaddr_t addr, input int n, input int x);
		req_t r;
		r.addr   = addr;
		r.nchunk = n;
		r.xmask  = x;
		req_q.push_back(r);
	endtask

	task automatic queue_random(input int count);
		for (int i = 0; i < count; i++) begin
			queue_request(tile_read_pkg::gaddr_t'($urandom()),
				$urandom_range(1, tile_read_pkg::MAX_CHUNKS),
				$urandom_range(0, tile_read_pkg::VSIZE - 1));
		end
	endtask

	// closing line and verdict
	task automatic end_run();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, u_checker.checks, u_checker.errors);
		if (timed_out || tests_failed != 0 || u_checker.errors != 0) begin
			$display("STATUS: FAIL");
		end else begin
			$display("STATUS: PASS");
		end
		$finish;
	endtask

	task automatic finish_test();
		int c;
		int e;
		c = u_checker.checks - checks_seen;
		e = u_checker.errors - errors_seen;
		checks_seen = u_checker.checks;
		errors_seen = u_checker.errors;
		tests_run++;
		if (e != 0 || c == 0 || timed_out) begin
			tests_failed++;
		end
		$display("test %s: %0d checks, %0d errors", u_checker.test_name, c, e);
		if (c == 0) begin
			$display("test %s made no checks at all", u_checker.test_name);
		end
	endtask

	// waits sample mid-cycle between the drive and the next edge
	task automatic wait_drain();
		int waited;
		waited = 0;
		while (!timed_out &&
			(u_checker.pending() != 0 || req_q.size() != 0 || i_req_valid)) begin
			if (waited == TIMEOUT) begin
				$display("timeout in %s, %0d expected transfers never came",
					u_checker.test_name, u_checker.pending());
				timed_out = 1'b1;
			end else begin
				waited++;
				@(posedge i_clk);
				#2;
			end
		end
	endtask

	task automatic wait_slots_full();
		int waited;
		waited = 0;
		while (!timed_out && u_checker.in_use < N_SLOTS) begin
			if (waited == TIMEOUT) begin
				$display("timeout in %s, only %0d slots ever held",
					u_checker.test_name, u_checker.in_use);
				timed_out = 1'b1;
			end else begin
				waited++;
				@(posedge i_clk);
				#2;
			end
		end
	endtask

	initial begin
		void'($urandom(68));
		i_rst          = 1'b1;
		i_req_valid    = 1'b0;
		i_req_addr     = '0;
		i_req_nchunk   = '0;
		i_req_xor      = '0;
		i_dramra_ready = 1'b1;
		i_dramrd_valid = 1'b0;
		i_dramrd_data  = '0;
		i_rd_ready     = 1'b1;
		gap            = 0;
		ra_random      = 1'b0;
		rd_mode        = 0;
		tests_run      = 0;
		tests_failed   = 0;
		checks_seen    = 0;
		errors_seen    = 0;
		timed_out      = 1'b0;

		u_checker.start_test("reset");
		#1 i_rst = 1'b0;
		repeat (10) @(posedge i_clk);
		#1 i_rst = 1'b1;
		@(posedge i_clk);
		#2;
		finish_test();

		u_checker.start_test("single_block");
		queue_request(24'h001230, 1, 0);
		wait_drain();
		finish_test();

		if (!timed_out) begin
			u_checker.start_test("random_stream");
			queue_random(60);
			wait_drain();
			finish_test();
		end

		if (!timed_out) begin
			u_checker.start_test("back_pressure");
			ra_random = 1'b1;
			rd_mode   = 1;
			queue_random(40);
			wait_drain();
			ra_random = 1'b0;
			rd_mode   = 0;
			finish_test();
		end

		// with the output stalled the slots fill and requests back up
		if (!timed_out) begin
			u_checker.start_test("slot_limit");
			rd_mode = 2;
			queue_random(N_SLOTS + 3);
			wait_slots_full();
			repeat (20) @(posedge i_clk);
			#2;
			rd_mode = 0;
			wait_drain();
			finish_test();
		end

		end_run();
	end
endmodule
